// File: croc_lite_pkg.sv
package croc_lite_pkg;

  // ----------------------------------------------------------------------
  // Widths and basic types
  // ----------------------------------------------------------------------
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  localparam int unsigned GpioCount = 8;
  typedef logic [GpioCount-1:0] gpio_t;

  localparam int unsigned NumExternalIrqs = 4;
  localparam int unsigned NumIrqs         = 16;
  typedef logic [NumIrqs-1:0] irq_vec_t;

  // Fixed positions inside the interrupt vector
  localparam int unsigned IrqGpioBit = 2;
  localparam int unsigned IrqExtBase = 3;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam data_t       SramBaseAddr = 32'h1000_0000;
  localparam int unsigned SramNumWords = 256;
  localparam int unsigned SramAddrBits = 8;
  localparam data_t       SramSize     = data_t'(SramNumWords * BeWidth);

  localparam data_t       PeriphBaseAddr = 32'h0300_0000;
  localparam data_t       PeriphSize     = 32'h0001_0000;
  localparam int unsigned PeriphOffBits  = 16;
  // 4 KiB windows inside peripheral space
  localparam int unsigned PeriphWinBits  = 12;

  typedef logic [PeriphOffBits-PeriphWinBits-1:0] win_idx_t;
  typedef logic [PeriphWinBits-1:0]               reg_off_t;

  localparam data_t    SocCtrlOffset = 32'h0000_0000;
  localparam data_t    GpioOffset    = 32'h0000_5000;
  localparam win_idx_t SocCtrlWin    = SocCtrlOffset[PeriphOffBits-1:PeriphWinBits];
  localparam win_idx_t GpioWin       = GpioOffset[PeriphOffBits-1:PeriphWinBits];

  // Control register offsets
  localparam reg_off_t RegBootAddr = 12'h000;
  localparam reg_off_t RegFetchEn  = 12'h004;

  // GPIO register offsets
  localparam reg_off_t GpioRegDir       = 12'h000;
  localparam reg_off_t GpioRegOut       = 12'h004;
  localparam reg_off_t GpioRegIn        = 12'h008;
  localparam reg_off_t GpioRegIrqEn     = 12'h00C;
  localparam reg_off_t GpioRegIrqStatus = 12'h010;

  // ----------------------------------------------------------------------
  // Bus channels
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    data_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Target side response, grant is handled by the router
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } tgt_rsp_t;

  localparam data_t    ErrRspData = 32'hBADC_AB1E;
  localparam tgt_rsp_t ErrRsp     = '{rvalid: 1'b1, rdata: ErrRspData, err: 1'b1};

endpackage

// File: sram_bank.sv
`timescale 1ns/1ps

module sram_bank import croc_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output tgt_rsp_t rsp_o
);

  logic [SramAddrBits-1:0] word_idx;
  data_t                   mem_q [SramNumWords];
  data_t                   rdata_q;
  logic                    rvalid_q;

  // Word index from the byte address
  assign word_idx = req_i.addr[SramAddrBits+1:2];

  // Array and read data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // A word access never fails inside the bank
  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

endmodule

// File: soc_ctrl_regs.sv
`timescale 1ns/1ps

module soc_ctrl_regs import croc_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  input  logic     fetch_en_i,
  output tgt_rsp_t rsp_o,
  output data_t    boot_addr_o,
  output logic     fetch_enable_o
);

  reg_off_t off;
  logic     wr_en;
  data_t    boot_addr_q;
  logic     fetch_en_q;
  logic     rvalid_q;
  data_t    rdata_q;

  assign off   = req_i.addr[PeriphWinBits-1:0];
  assign wr_en = req_i.req & req_i.we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && (off == RegBootAddr)) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (req_i.be[b]) begin
            boot_addr_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      if (wr_en && (off == RegFetchEn) && req_i.be[0]) begin
        fetch_en_q <= req_i.wdata[0];
      end
    end
  end

  // Read data, other offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= '0;
      if (!req_i.we) begin
        case (off)
          RegBootAddr: rdata_q <= boot_addr_q;
          RegFetchEn:  rdata_q <= data_t'(fetch_en_q);
          default:     rdata_q <= '0;
        endcase
      end
    end
  end

  assign rsp_o          = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};
  assign boot_addr_o    = boot_addr_q;
  // External pin can start the core without a bus write
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// File: gpio_unit.sv
`timescale 1ns/1ps

module gpio_unit import croc_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  input  gpio_t    gpio_i,
  output tgt_rsp_t rsp_o,
  output gpio_t    gpio_o,
  output gpio_t    gpio_out_en_o,
  output gpio_t    gpio_in_sync_o,
  output logic     irq_o
);

  reg_off_t off;
  logic     wr_en;
  gpio_t    in_meta_q;
  gpio_t    in_sync_q;
  gpio_t    in_prev_q;
  gpio_t    rise;
  gpio_t    dir_q;
  gpio_t    out_q;
  gpio_t    irq_en_q;
  gpio_t    status_q;
  gpio_t    status_clr;
  logic     rvalid_q;
  data_t    rdata_q;

  assign off = req_i.addr[PeriphWinBits-1:0];
  // Registers are 8 bits wide, only the low byte lane matters
  assign wr_en = req_i.req & req_i.we & req_i.be[0];

  // ----------------------------------------------------------------------
  // Input synchroniser and edge detect
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  assign rise       = in_sync_q & ~in_prev_q;
  assign status_clr = (wr_en && (off == GpioRegIrqStatus)) ? req_i.wdata[GpioCount-1:0] : '0;

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      // New edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
      if (wr_en) begin
        case (off)
          GpioRegDir:   dir_q    <= req_i.wdata[GpioCount-1:0];
          GpioRegOut:   out_q    <= req_i.wdata[GpioCount-1:0];
          GpioRegIrqEn: irq_en_q <= req_i.wdata[GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= '0;
      if (!req_i.we) begin
        case (off)
          GpioRegDir:       rdata_q <= data_t'(dir_q);
          GpioRegOut:       rdata_q <= data_t'(out_q);
          GpioRegIn:        rdata_q <= data_t'(in_sync_q);
          GpioRegIrqEn:     rdata_q <= data_t'(irq_en_q);
          GpioRegIrqStatus: rdata_q <= data_t'(status_q);
          default:          rdata_q <= '0;
        endcase
      end
    end
  end

  assign rsp_o          = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = in_sync_q;
  assign irq_o          = |status_q;

endmodule

// File: periph_block.sv
`timescale 1ns/1ps

module periph_block import croc_lite_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  bus_req_t                   req_i,
  output tgt_rsp_t                   rsp_o,
  input  logic                       fetch_en_i,
  output data_t                      boot_addr_o,
  output logic                       fetch_enable_o,
  input  gpio_t                      gpio_i,
  output gpio_t                      gpio_o,
  output gpio_t                      gpio_out_en_o,
  output gpio_t                      gpio_in_sync_o,
  input  logic [NumExternalIrqs-1:0] interrupts_i,
  output irq_vec_t                   irq_o
);

  win_idx_t win;
  logic     ctrl_hit;
  logic     gpio_hit;
  logic     err_q;
  logic     gpio_irq;
  bus_req_t ctrl_req;
  bus_req_t gpio_req;
  tgt_rsp_t ctrl_rsp;
  tgt_rsp_t gpio_rsp;

  // ----------------------------------------------------------------------
  // Window decode
  // ----------------------------------------------------------------------
  assign win      = req_i.addr[PeriphOffBits-1:PeriphWinBits];
  assign ctrl_hit = (win == SocCtrlWin);
  assign gpio_hit = (win == GpioWin);

  always_comb begin
    ctrl_req     = req_i;
    ctrl_req.req = req_i.req & ctrl_hit;
    gpio_req     = req_i;
    gpio_req.req = req_i.req & gpio_hit;
  end

  // Unmapped windows get the error word one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.req & ~ctrl_hit & ~gpio_hit;
    end
  end

  always_comb begin
    rsp_o = ctrl_rsp;
    if (err_q) begin
      rsp_o = ErrRsp;
    end else if (gpio_rsp.rvalid) begin
      rsp_o = gpio_rsp;
    end
  end

  // ----------------------------------------------------------------------
  // Peripherals
  // ----------------------------------------------------------------------
  soc_ctrl_regs u_soc_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( ctrl_req       ),
    .fetch_en_i     ( fetch_en_i     ),
    .rsp_o          ( ctrl_rsp       ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o )
  );

  gpio_unit u_gpio (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( gpio_req       ),
    .gpio_i         ( gpio_i         ),
    .rsp_o          ( gpio_rsp       ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .irq_o          ( gpio_irq       )
  );

  // Interrupt vector, unused lines tied low
  always_comb begin
    irq_o                               = '0;
    irq_o[IrqGpioBit]                   = gpio_irq;
    irq_o[IrqExtBase +: NumExternalIrqs] = interrupts_i;
  end

endmodule

// File: bus_router.sv
`timescale 1ns/1ps

module bus_router import croc_lite_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,

  output bus_req_t sram_req_o,
  input  tgt_rsp_t sram_rsp_i,

  output bus_req_t periph_req_o,
  input  tgt_rsp_t periph_rsp_i
);

  logic     sram_hit;
  logic     periph_hit;
  logic     sram_sel_q;
  logic     periph_sel_q;
  logic     err_sel_q;
  tgt_rsp_t rsp;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  // Offset compare wraps below the base, so one check covers both bounds
  assign sram_hit   = (bus_req_i.addr - SramBaseAddr) < SramSize;
  assign periph_hit = (bus_req_i.addr - PeriphBaseAddr) < PeriphSize;

  always_comb begin
    sram_req_o       = bus_req_i;
    sram_req_o.req   = bus_req_i.req & sram_hit;
    periph_req_o     = bus_req_i;
    periph_req_o.req = bus_req_i.req & periph_hit;
  end

  // ----------------------------------------------------------------------
  // Response tracking
  // ----------------------------------------------------------------------
  // Target of the request accepted last cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sram_sel_q   <= 1'b0;
      periph_sel_q <= 1'b0;
      err_sel_q    <= 1'b0;
    end else begin
      sram_sel_q   <= sram_req_o.req;
      periph_sel_q <= periph_req_o.req;
      err_sel_q    <= bus_req_i.req & ~sram_hit & ~periph_hit;
    end
  end

  // Only one selection can be set at a time
  always_comb begin
    rsp = '0;
    if (err_sel_q) begin
      rsp = ErrRsp;
    end else if (sram_sel_q) begin
      rsp = sram_rsp_i;
    end else if (periph_sel_q) begin
      rsp = periph_rsp_i;
    end
  end

  // Every request is granted in the cycle it is raised
  always_comb begin
    bus_rsp_o.gnt    = bus_req_i.req;
    bus_rsp_o.rvalid = rsp.rvalid;
    bus_rsp_o.rdata  = rsp.rdata;
    bus_rsp_o.err    = rsp.err;
  end

endmodule

// File: croc_lite_domain.sv
`timescale 1ns/1ps

module croc_lite_domain import croc_lite_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  bus_req_t                   bus_req_i,
  output bus_rsp_t                   bus_rsp_o,

  input  logic                       fetch_en_i,
  output data_t                      boot_addr_o,
  output logic                       fetch_enable_o,

  input  gpio_t                      gpio_i,
  output gpio_t                      gpio_o,
  output gpio_t                      gpio_out_en_o,
  output gpio_t                      gpio_in_sync_o,

  input  logic [NumExternalIrqs-1:0] interrupts_i,
  output irq_vec_t                   irq_o
);

  // Router to target links
  bus_req_t sram_req;
  tgt_rsp_t sram_rsp;
  bus_req_t periph_req;
  tgt_rsp_t periph_rsp;

  bus_router u_router (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .bus_req_i    ( bus_req_i  ),
    .bus_rsp_o    ( bus_rsp_o  ),
    .sram_req_o   ( sram_req   ),
    .sram_rsp_i   ( sram_rsp   ),
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  sram_bank u_sram (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .req_i   ( sram_req ),
    .rsp_o   ( sram_rsp )
  );

  periph_block u_periph (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( periph_req     ),
    .rsp_o          ( periph_rsp     ),
    .fetch_en_i     ( fetch_en_i     ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .interrupts_i   ( interrupts_i   ),
    .irq_o          ( irq_o          )
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam time         ClkPeriod = 100ns;
  localparam int unsigned RstCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the stimulus slot
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_croc_lite_domain.sv
`timescale 1ns/1ps

module tb_croc_lite_domain import croc_lite_pkg::*; ();

  localparam time         DriveDelay = 10ns;
  localparam int unsigned MaxWait    = 16;
  localparam data_t       CtrlBase   = PeriphBaseAddr + SocCtrlOffset;
  localparam data_t       GpioBase   = PeriphBaseAddr + GpioOffset;
  localparam int unsigned NumWords   = 16;
  localparam int unsigned PipeLen    = 8;

  logic                       clk;
  logic                       rst_n;
  bus_req_t                   bus_req;
  bus_rsp_t                   bus_rsp;
  logic                       fetch_en;
  data_t                      boot_addr;
  logic                       fetch_enable;
  gpio_t                      gpio_in;
  gpio_t                      gpio_out;
  gpio_t                      gpio_oe;
  gpio_t                      gpio_sync;
  logic [NumExternalIrqs-1:0] ext_irqs;
  irq_vec_t                   irq_vec;

  logic [31:0] lfsr_q;
  data_t       sram_model [SramNumWords];
  data_t       boot_model;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  croc_lite_domain u_dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .bus_req_i      ( bus_req      ),
    .bus_rsp_o      ( bus_rsp      ),
    .fetch_en_i     ( fetch_en     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_oe      ),
    .gpio_in_sync_o ( gpio_sync    ),
    .interrupts_i   ( ext_irqs     ),
    .irq_o          ( irq_vec      )
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic data_t lfsr_bits(input int unsigned n);
    data_t val;
    logic  fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t new_w, input be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bus_rsp_t make_rsp(input data_t rdata, input logic err);
    return '{gnt: 1'b1, rvalid: 1'b1, rdata: rdata, err: err};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #(DriveDelay);
  endtask

  task automatic halt_on_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic abort_after_timeout(input string what);
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
    $display("tests failed");
    $fatal(1, "Stopped on timeout");
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("%s: got gnt=%b rvalid=%b rdata=%h err=%b",
        what, got.gnt, got.rvalid, got.rdata, got.err);
      msg = {msg, $sformatf(", exp gnt=%b rvalid=%b rdata=%h err=%b",
        exp.gnt, exp.rvalid, exp.rdata, exp.err)};
      halt_on_mismatch(msg);
    end
  endtask

  task automatic check_word(input data_t got, input data_t exp, input string what);
    if (got !== exp) halt_on_mismatch($sformatf("%s: got %h, exp %h", what, got, exp));
  endtask

  task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
    if (got !== exp) halt_on_mismatch($sformatf("%s: got %b, exp %b", what, got, exp));
  endtask

  task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
    if (got !== exp) halt_on_mismatch($sformatf("%s: got %h, exp %h", what, got, exp));
  endtask

  task automatic check_latency(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp) halt_on_mismatch($sformatf("%s: latency %0d, exp %0d", what, got, exp));
  endtask

  // ----------------------------------------------------------------------
  // Bus access
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic we, input be_t be, input data_t addr,
                            input data_t wdata, output bus_rsp_t rsp, output int unsigned lat);
    logic gnt_seen;
    bus_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    #1;
    gnt_seen = bus_rsp.gnt;
    lat      = 0;
    rsp      = '0;
    while (rsp.rvalid !== 1'b1) begin
      next_cycle();
      lat++;
      rsp     = bus_rsp;
      bus_req = '0;
      if (rsp.rvalid !== 1'b1 && lat >= MaxWait) abort_after_timeout("rvalid");
    end
    rsp.gnt = gnt_seen;
  endtask

  task automatic write_expect(input data_t addr, input data_t wdata, input be_t be,
                              input string what);
    bus_rsp_t    rsp;
    int unsigned lat;
    bus_access(1'b1, be, addr, wdata, rsp, lat);
    check_rsp(rsp, make_rsp('0, 1'b0), what);
    check_latency(lat, 1, what);
  endtask

  task automatic read_expect(input data_t addr, input data_t exp, input string what);
    bus_rsp_t    rsp;
    int unsigned lat;
    bus_access(1'b0, 4'hF, addr, '0, rsp, lat);
    check_rsp(rsp, make_rsp(exp, 1'b0), what);
    check_latency(lat, 1, what);
  endtask

  task automatic wait_gpio_sync(input gpio_t pattern, output int unsigned cycles);
    cycles = 0;
    while (gpio_sync !== pattern) begin
      next_cycle();
      cycles++;
      if (gpio_sync !== pattern && cycles >= MaxWait) begin
        abort_after_timeout("synchronised GPIO input");
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic sram_readback();
    data_t addr;
    data_t wdata;
    be_t   be;
    for (int i = 0; i < NumWords; i++) begin
      addr  = SramBaseAddr + data_t'(((i * 17) % SramNumWords) * BeWidth);
      wdata = lfsr_bits(32);
      write_expect(addr, wdata, 4'hF, "SRAM full write");
      sram_model[(i * 17) % SramNumWords] = wdata;
      wdata = lfsr_bits(32);
      be    = be_t'(lfsr_bits(BeWidth));
      write_expect(addr, wdata, be, "SRAM byte write");
      sram_model[(i * 17) % SramNumWords] =
        merge_bytes(sram_model[(i * 17) % SramNumWords], wdata, be);
    end
    for (int i = 0; i < NumWords; i++) begin
      addr = SramBaseAddr + data_t'(((i * 17) % SramNumWords) * BeWidth);
      read_expect(addr, sram_model[(i * 17) % SramNumWords], "SRAM read back");
    end
  endtask

  task automatic error_space_rsp();
    data_t       bad_addr [4];
    bus_rsp_t    rsp;
    int unsigned lat;
    bad_addr = '{32'h0000_0000, 32'h2000_0000, SramBaseAddr + SramSize, PeriphBaseAddr + 32'h2000};
    foreach (bad_addr[i]) begin
      bus_access(1'b0, 4'hF, bad_addr[i], '0, rsp, lat);
      check_rsp(rsp, make_rsp(ErrRspData, 1'b1), $sformatf("error read at %h", bad_addr[i]));
      check_latency(lat, 1, "error read");
      bus_access(1'b1, 4'hF, bad_addr[i], lfsr_bits(32), rsp, lat);
      check_rsp(rsp, make_rsp(ErrRspData, 1'b1), $sformatf("error write at %h", bad_addr[i]));
      check_latency(lat, 1, "error write");
    end
  endtask

  task automatic ctrl_reg_access();
    data_t wdata;
    read_expect(CtrlBase + RegBootAddr, SramBaseAddr, "boot address after reset");
    check_word(boot_addr, SramBaseAddr, "boot_addr_o after reset");
    wdata = lfsr_bits(32);
    write_expect(CtrlBase + RegBootAddr, wdata, 4'hF, "boot address write");
    boot_model = wdata;
    wdata = lfsr_bits(32);
    write_expect(CtrlBase + RegBootAddr, wdata, 4'b0101, "boot address byte write");
    boot_model = merge_bytes(boot_model, wdata, 4'b0101);
    read_expect(CtrlBase + RegBootAddr, boot_model, "boot address read back");
    check_word(boot_addr, boot_model, "boot_addr_o after write");
    // All four register and pin combinations
    for (int c = 0; c < 4; c++) begin
      write_expect(CtrlBase + RegFetchEn, data_t'(c & 1), 4'hF, "fetch enable write");
      fetch_en = logic'(c >> 1);
      next_cycle();
      read_expect(CtrlBase + RegFetchEn, data_t'(c & 1), "fetch enable read back");
      check_word(data_t'(fetch_enable), data_t'((c & 1) | (c >> 1)), "fetch_enable_o");
    end
    fetch_en = 1'b0;
  endtask

  task automatic gpio_in_out();
    gpio_t       dir;
    gpio_t       out;
    gpio_t       pattern;
    int unsigned cycles;
    dir = gpio_t'(lfsr_bits(GpioCount));
    out = gpio_t'(lfsr_bits(GpioCount));
    write_expect(GpioBase + GpioRegDir, data_t'(dir), 4'h1, "GPIO direction write");
    write_expect(GpioBase + GpioRegOut, data_t'(out), 4'h1, "GPIO output write");
    check_gpio(gpio_oe, dir, "gpio_out_en_o");
    check_gpio(gpio_out, out, "gpio_o");
    read_expect(GpioBase + GpioRegDir, data_t'(dir), "GPIO direction read back");
    read_expect(GpioBase + GpioRegOut, data_t'(out), "GPIO output read back");
    pattern = gpio_t'(lfsr_bits(GpioCount)) | 8'h01;
    gpio_in = pattern;
    wait_gpio_sync(pattern, cycles);
    check_latency(cycles, 2, "GPIO input synchroniser");
    check_gpio(gpio_sync, pattern, "gpio_in_sync_o");
    read_expect(GpioBase + GpioRegIn, data_t'(pattern), "GPIO input register");
  endtask

  task automatic irq_lines();
    irq_vec_t                   exp;
    logic [NumExternalIrqs-1:0] ext;
    int unsigned                cycles;
    gpio_in = '0;
    wait_gpio_sync('0, cycles);
    next_cycle();
    // Edges seen so far came while every pin was disabled
    read_expect(GpioBase + GpioRegIrqStatus, '0, "IRQ status with pins disabled");
    write_expect(GpioBase + GpioRegIrqEn, 32'h01, 4'h1, "IRQ enable write");
    write_expect(GpioBase + GpioRegIrqStatus, 32'hFF, 4'h1, "IRQ status clear");
    check_irq(irq_vec, '0, "irq_o idle");
    // Pin 1 is not enabled
    gpio_in = 8'h02;
    repeat (5) next_cycle();
    check_irq(irq_vec, '0, "irq_o after disabled edge");
    read_expect(GpioBase + GpioRegIrqStatus, '0, "IRQ status after disabled edge");
    gpio_in = 8'h03;
    cycles  = 0;
    while (irq_vec[IrqGpioBit] !== 1'b1) begin
      next_cycle();
      cycles++;
      if (irq_vec[IrqGpioBit] !== 1'b1 && cycles >= MaxWait) begin
        abort_after_timeout("GPIO interrupt");
      end
    end
    exp             = '0;
    exp[IrqGpioBit] = 1'b1;
    check_irq(irq_vec, exp, "irq_o after enabled edge");
    read_expect(GpioBase + GpioRegIrqStatus, 32'h01, "IRQ status after enabled edge");
    write_expect(GpioBase + GpioRegIrqStatus, 32'h01, 4'h1, "IRQ status write one to clear");
    check_irq(irq_vec, '0, "irq_o after clear");
    for (int i = 0; i < 5; i++) begin
      ext      = (i == 4) ? '1 : NumExternalIrqs'(lfsr_bits(NumExternalIrqs));
      ext_irqs = ext;
      next_cycle();
      exp                                = '0;
      exp[IrqExtBase +: NumExternalIrqs] = ext;
      check_irq(irq_vec, exp, "external interrupt lines");
    end
    ext_irqs = '0;
  endtask

  task automatic pipelined_reads();
    data_t addr [PipeLen];
    data_t exp  [PipeLen];
    for (int k = 0; k < PipeLen; k++) begin
      if (k % 2 == 0) begin
        addr[k] = SramBaseAddr + data_t'((((k / 2) * 17) % SramNumWords) * BeWidth);
        exp[k]  = sram_model[((k / 2) * 17) % SramNumWords];
      end else begin
        addr[k] = CtrlBase + RegBootAddr;
        exp[k]  = boot_model;
      end
    end
    bus_req = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: addr[0], wdata: '0};
    for (int k = 1; k <= PipeLen; k++) begin
      next_cycle();
      check_rsp(bus_rsp, make_rsp(exp[k-1], 1'b0), $sformatf("pipelined read %0d", k - 1));
      if (k < PipeLen) begin
        bus_req.addr = addr[k];
      end else begin
        bus_req = '0;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned cycles;
    lfsr_q     = 32'd88133;
    boot_model = SramBaseAddr;
    bus_req    = '0;
    fetch_en   = 1'b0;
    gpio_in    = '0;
    ext_irqs   = '0;
    cycles     = 0;
    while (rst_n !== 1'b1) begin
      next_cycle();
      cycles++;
      if (rst_n !== 1'b1 && cycles >= MaxWait) abort_after_timeout("reset release");
    end
    check_rsp(bus_rsp, '0, "bus response after reset");
    check_gpio(gpio_out, '0, "gpio_o after reset");
    check_gpio(gpio_oe, '0, "gpio_out_en_o after reset");
    check_word(data_t'(fetch_enable), '0, "fetch_enable_o after reset");
    check_irq(irq_vec, '0, "irq_o after reset");
    sram_readback();
    error_space_rsp();
    ctrl_reg_access();
    gpio_in_out();
    irq_lines();
    pipelined_reads();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: vlog.f
croc_lite_pkg.sv
sram_bank.sv
soc_ctrl_regs.sv
gpio_unit.sv
periph_block.sv
bus_router.sv
croc_lite_domain.sv
tb_clk_gen.sv
tb_croc_lite_domain.sv

// File: Bender.yml
package:
  name: croc_lite_domain

sources:
  - files:
      - croc_lite_pkg.sv
      - sram_bank.sv
      - soc_ctrl_regs.sv
      - gpio_unit.sv
      - periph_block.sv
      - bus_router.sv
      - croc_lite_domain.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_croc_lite_domain.sv
